/* common/alu_fmt_pkg.sv */
// number formats of the dot-product datapath: lane count, widths and signed lane types
`default_nettype none

package alu_fmt_pkg;

    // lanes per beat
    localparam int unsigned lane_count = 4;

    // operand width of matrix and vector values
    localparam int unsigned opnd_w = 8;

    // full product of two operands
    localparam int unsigned prod_w = 16;

    // sum of two products, one growth bit
    localparam int unsigned part_w = 17;

    // result slot, sign-extended segment sum
    localparam int unsigned res_w = 26;

    typedef logic signed [opnd_w-1:0] opnd_t;
    typedef logic signed [prod_w-1:0] prod_t;
    typedef logic signed [part_w-1:0] part_t;
    typedef logic signed [res_w-1:0]  res_t;

endpackage

`default_nettype wire

/* common/seg_pkg.sv */
// break-pattern type and the segment slot and count rules
`default_nettype none

package seg_pkg;

    // bit i set ends a segment after lane i
    typedef logic [alu_fmt_pkg::lane_count-2:0] pattern_t;

    // all four lanes in one segment
    localparam pattern_t no_breaks = '0;

    // slot that takes the segment starting at a lane
    // equals the number of breaks below that lane
    function automatic int unsigned seg_slot(pattern_t p, int unsigned lane);
        int unsigned slot;
        slot = 0;
        for (int unsigned j = 0; j < $bits(pattern_t); j++) begin
            if (j < lane && p[j]) begin
                slot++;
            end
        end
        return slot;
    endfunction

    // segments in a beat, one more than the breaks
    function automatic int unsigned seg_count(pattern_t p);
        return seg_slot(p, alu_fmt_pkg::lane_count) + 1;
    endfunction

endpackage

`default_nettype wire

/* common/lane_if.sv */
// one beat between pipeline stages: lane values, break pattern and valid
`default_nettype none

interface lane_if #(
    parameter int unsigned lane_w = 16
);

    logic signed [lane_w-1:0] lanes [alu_fmt_pkg::lane_count];
    seg_pkg::pattern_t        pattern;
    logic                     valid;

    // producing stage
    modport src (
        output lanes,
        output pattern,
        output valid
    );

    // consuming stage
    modport dst (
        input lanes,
        input pattern,
        input valid
    );

endinterface

`default_nettype wire

/* source/product_stage.sv */
// first pipeline level: four signed lane multiplies with registered pattern and valid
`default_nettype none

module product_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  alu_fmt_pkg::opnd_t mat_lanes [alu_fmt_pkg::lane_count],
    input  alu_fmt_pkg::opnd_t vec_lanes [alu_fmt_pkg::lane_count],
    input  seg_pkg::pattern_t  pattern,
    lane_if.src                prod_out
);

    alu_fmt_pkg::prod_t prod [alu_fmt_pkg::lane_count];

    // 8x8 signed fits 16 bits, -128 * -128 included
    always_comb begin
        for (int i = 0; i < alu_fmt_pkg::lane_count; i++) begin
            prod[i] = mat_lanes[i] * vec_lanes[i];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prod_out.valid <= 1'b0;
        end else begin
            prod_out.valid <= in_valid;
        end
    end

    // products and pattern follow the beat every edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < alu_fmt_pkg::lane_count; i++) begin
            prod_out.lanes[i] <= prod[i];
        end
        prod_out.pattern <= pattern;
    end

endmodule

`default_nettype wire

/* reduce/pair_merge_stage.sv */
// second pipeline level: merges lane pairs 0-1 and 2-3 unless a break separates them
`default_nettype none

module pair_merge_stage (
    input  logic clk,
    input  logic rst,
    lane_if.dst  prod_in,
    lane_if.src  pair_out
);

    localparam int unsigned pair_count = alu_fmt_pkg::lane_count / 2;

    alu_fmt_pkg::part_t merged [alu_fmt_pkg::lane_count];

    // pair k covers lanes 2k and 2k+1, split by pattern bit 2k
    always_comb begin
        for (int k = 0; k < pair_count; k++) begin
            if (!prod_in.pattern[2*k]) begin
                // same segment, sum lands in the lower lane
                merged[2*k]   = alu_fmt_pkg::part_t'(prod_in.lanes[2*k])
                              + alu_fmt_pkg::part_t'(prod_in.lanes[2*k+1]);
                merged[2*k+1] = '0;
            end else begin
                merged[2*k]   = alu_fmt_pkg::part_t'(prod_in.lanes[2*k]);
                merged[2*k+1] = alu_fmt_pkg::part_t'(prod_in.lanes[2*k+1]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pair_out.valid <= 1'b0;
        end else begin
            pair_out.valid <= prod_in.valid;
        end
    end

    // partials and pattern move on every edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < alu_fmt_pkg::lane_count; i++) begin
            pair_out.lanes[i] <= merged[i];
        end
        pair_out.pattern <= prod_in.pattern;
    end

endmodule

`default_nettype wire

/* reduce/segment_pack_stage.sv */
// last pipeline level: joins across lanes 1-2, packs segment sums left-aligned into slots
`default_nettype none

module segment_pack_stage (
    input  logic              clk,
    input  logic              rst,
    lane_if.dst               pair_in,
    output logic              out_valid,
    output alu_fmt_pkg::res_t res_slots [alu_fmt_pkg::lane_count]
);

    alu_fmt_pkg::res_t                 grp [alu_fmt_pkg::lane_count];
    alu_fmt_pkg::res_t                 slots_next [alu_fmt_pkg::lane_count];
    logic [alu_fmt_pkg::lane_count-1:0] seg_start;
    int unsigned                       seg_total;

    // after this block each segment sum sits in its first lane
    always_comb begin
        for (int i = 0; i < alu_fmt_pkg::lane_count; i++) begin
            grp[i] = alu_fmt_pkg::res_t'(pair_in.lanes[i]);
        end
        if (!pair_in.pattern[1]) begin
            // right group joins whichever lane holds lane 1's partial
            if (pair_in.pattern[0]) begin
                grp[1] = grp[1] + grp[2];
            end else begin
                grp[0] = grp[0] + grp[2];
            end
            grp[2] = '0;
        end
    end

    // lane 0 always opens a segment, any other lane only after a break
    always_comb begin
        seg_start[0] = 1'b1;
        for (int i = 1; i < alu_fmt_pkg::lane_count; i++) begin
            seg_start[i] = pair_in.pattern[i-1];
        end
    end

    assign seg_total = seg_pkg::seg_count(pair_in.pattern);

    // slot s takes the segment whose start lane has s breaks below it
    always_comb begin
        for (int s = 0; s < alu_fmt_pkg::lane_count; s++) begin
            slots_next[s] = '0;
            if (s < seg_total) begin
                for (int i = 0; i < alu_fmt_pkg::lane_count; i++) begin
                    if (seg_start[i] && seg_pkg::seg_slot(pair_in.pattern, i) == s) begin
                        slots_next[s] = grp[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
            for (int s = 0; s < alu_fmt_pkg::lane_count; s++) begin
                res_slots[s] <= '0;
            end
        end else begin
            out_valid <= pair_in.valid;
            for (int s = 0; s < alu_fmt_pkg::lane_count; s++) begin
                res_slots[s] <= slots_next[s];
            end
        end
    end

endmodule

`default_nettype wire

/* source/matvec_alu_top.sv */
// top level of the segmented dot-product unit: operand unpacking and stage chain
`default_nettype none

module matvec_alu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [alu_fmt_pkg::lane_count*alu_fmt_pkg::opnd_w-1:0] mat_word,
    input  logic [alu_fmt_pkg::lane_count*alu_fmt_pkg::opnd_w-1:0] vec_word,
    input  seg_pkg::pattern_t    pattern,
    output logic                 out_valid,
    output alu_fmt_pkg::res_t    res_0,
    output alu_fmt_pkg::res_t    res_1,
    output alu_fmt_pkg::res_t    res_2,
    output alu_fmt_pkg::res_t    res_3
);

    alu_fmt_pkg::opnd_t mat_lanes [alu_fmt_pkg::lane_count];
    alu_fmt_pkg::opnd_t vec_lanes [alu_fmt_pkg::lane_count];
    alu_fmt_pkg::res_t  res_slots [alu_fmt_pkg::lane_count];

    lane_if #(.lane_w(alu_fmt_pkg::prod_w)) prod_bus ();
    lane_if #(.lane_w(alu_fmt_pkg::part_w)) pair_bus ();

    // lane 0 sits in the top byte
    for (genvar gi = 0; gi < alu_fmt_pkg::lane_count; gi++) begin : g_unpack
        localparam int unsigned top_bit = alu_fmt_pkg::opnd_w * (alu_fmt_pkg::lane_count - gi) - 1;
        assign mat_lanes[gi] = mat_word[top_bit -: alu_fmt_pkg::opnd_w];
        assign vec_lanes[gi] = vec_word[top_bit -: alu_fmt_pkg::opnd_w];
    end

    product_stage u_product (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .mat_lanes (mat_lanes),
        .vec_lanes (vec_lanes),
        .pattern   (pattern),
        .prod_out  (prod_bus.src)
    );

    pair_merge_stage u_pair_merge (
        .clk      (clk),
        .rst      (rst),
        .prod_in  (prod_bus.dst),
        .pair_out (pair_bus.src)
    );

    segment_pack_stage u_segment_pack (
        .clk       (clk),
        .rst       (rst),
        .pair_in   (pair_bus.dst),
        .out_valid (out_valid),
        .res_slots (res_slots)
    );

    assign res_0 = res_slots[0];
    assign res_1 = res_slots[1];
    assign res_2 = res_slots[2];
    assign res_3 = res_slots[3];

endmodule

`default_nettype wire

/* dv/tb_vectors.svh */
// directed stimulus rows with expected result slots for the dot-product testbench
`ifndef tb_vectors_svh
`define tb_vectors_svh

// columns: test id, matrix word, vector word (lane 0 in top byte), pattern,
// expected slot 0, slot 1, slot 2, slot 3
localparam int table_rows = 13;

localparam table_row_t vector_table [table_rows] = '{
    // one segment, extremes included
    '{3'd2, 32'h80808080, 32'h80808080, 3'b000, 26'sd65536, 26'sd0, 26'sd0, 26'sd0},
    '{3'd2, 32'h80808080, 32'h7f7f7f7f, 3'b000, -26'sd65024, 26'sd0, 26'sd0, 26'sd0},
    '{3'd2, 32'h01020304, 32'h05060708, 3'b000, 26'sd70, 26'sd0, 26'sd0, 26'sd0},
    // every lane its own segment
    '{3'd3, 32'h01020304, 32'h05060708, 3'b111, 26'sd5, 26'sd12, 26'sd21, 26'sd32},
    '{3'd3, 32'h80807fff, 32'h807f7f02, 3'b111, 26'sd16384, -26'sd16256, 26'sd16129, -26'sd2},
    // products 5, -12, -21, -32 under all eight patterns
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b000, -26'sd60, 26'sd0, 26'sd0, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b001, 26'sd5, -26'sd65, 26'sd0, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b010, -26'sd7, -26'sd53, 26'sd0, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b011, 26'sd5, -26'sd12, -26'sd53, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b100, -26'sd28, -26'sd32, 26'sd0, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b101, 26'sd5, -26'sd33, -26'sd32, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b110, -26'sd7, -26'sd21, -26'sd32, 26'sd0},
    '{3'd4, 32'h01fe03fc, 32'h0506f908, 3'b111, 26'sd5, -26'sd12, -26'sd21, -26'sd32}
};

`endif

/* dv/tb_matvec_alu.sv */
// clock, reset, reference model, drive loop and checks for the segmented dot-product unit
`default_nettype none

module tb_matvec_alu;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [2:0]  test_id;
        logic [31:0] mat;
        logic [31:0] vec;
        logic [2:0]  pat;
        logic [25:0] e0;
        logic [25:0] e1;
        logic [25:0] e2;
        logic [25:0] e3;
    } table_row_t;

    // one beat in flight and the edge at which its result must show
    typedef struct packed {
        logic [31:0]      due;
        logic [2:0]       test_id;
        logic [3:0][25:0] slots;
    } beat_exp_t;

    `include "tb_vectors.svh"

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic [31:0]        mat_word;
    logic [31:0]        vec_word;
    logic [2:0]         pattern;
    logic               out_valid;
    logic signed [25:0] res_0;
    logic signed [25:0] res_1;
    logic signed [25:0] res_2;
    logic signed [25:0] res_3;

    int          edge_count = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_passed = 0;
    logic [2:0]  active_test = 3'd1;
    logic [31:0] lfsr_state = 32'h6288;
    beat_exp_t   pending [$];

    matvec_alu_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .mat_word  (mat_word),
        .vec_word  (vec_word),
        .pattern   (pattern),
        .out_valid (out_valid),
        .res_0     (res_0),
        .res_1     (res_1),
        .res_2     (res_2),
        .res_3     (res_3)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] next_random_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // walk the lanes and close a segment at each break or at the last lane
    function automatic logic [3:0][25:0] segment_sums(input logic [31:0] mat,
                                                      input logic [31:0] vec,
                                                      input logic [2:0]  pat);
        logic [3:0][25:0]  slots;
        logic signed [7:0] a;
        logic signed [7:0] b;
        int                sum;
        int                slot;
        slots = '0;
        sum = 0;
        slot = 0;
        for (int lane = 0; lane < 4; lane++) begin
            a = mat[31-8*lane -: 8];
            b = vec[31-8*lane -: 8];
            sum = sum + a * b;
            if (lane == 3 || pat[lane]) begin
                slots[slot] = 26'(sum);
                sum = 0;
                slot++;
            end
        end
        return slots;
    endfunction

    function automatic string test_name(input logic [2:0] test_id);
        case (test_id)
            3'd1:    return "reset_state";
            3'd2:    return "single_segment";
            3'd3:    return "all_breaks";
            3'd4:    return "every_pattern";
            3'd5:    return "back_to_back";
            default: return "valid_gaps";
        endcase
    endfunction

    // compares one cycle of outputs against the oldest beat in flight
    task automatic check_outputs();
        logic [3:0][25:0] got;
        beat_exp_t        head;
        got = {res_3, res_2, res_1, res_0};
        if (pending.size() != 0 && pending[0].due == edge_count) begin
            head = pending.pop_front();
            assert (out_valid === 1'b1) else begin
                $display("CHECK FAILED %s out_valid: expected 1, actual %b",
                         test_name(head.test_id), out_valid);
                errors++;
            end
            for (int s = 0; s < 4; s++) begin
                assert (got[s] === head.slots[s]) else begin
                    $display("CHECK FAILED %s slot %0d: expected %0d, actual %0d",
                             test_name(head.test_id), s,
                             $signed(head.slots[s]), $signed(got[s]));
                    errors++;
                end
            end
        end else begin
            assert (out_valid === 1'b0) else begin
                $display("CHECK FAILED %s out_valid: expected 0, actual %b",
                         test_name(active_test), out_valid);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (rst) begin
            check_outputs();
        end
    end

    task automatic send_beat(input logic [31:0] mat, input logic [31:0] vec,
                             input logic [2:0] pat, input logic [3:0][25:0] slots,
                             input logic [2:0] test_id);
        beat_exp_t entry;
        in_valid = 1'b1;
        mat_word = mat;
        vec_word = vec;
        pattern = pat;
        entry.due = edge_count + 3;
        entry.test_id = test_id;
        entry.slots = slots;
        pending.push_back(entry);
        @(posedge clk);
        #2;
    endtask

    // junk on the data lines while in_valid is low
    task automatic idle_cycle();
        in_valid = 1'b0;
        mat_word = next_random_bits(32);
        vec_word = next_random_bits(32);
        pattern = 3'(next_random_bits(3));
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (pending.size() != 0 && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (pending.size() != 0) begin
            $display("timeout: %0d results never appeared", pending.size());
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic report_test(input logic [2:0] test_id, input int start_errors);
        int failed;
        failed = errors - start_errors;
        tests_run++;
        if (failed == 0) begin
            tests_passed++;
            $display("test %-15s passed", test_name(test_id));
        end else begin
            $display("test %-15s FAILED with %0d bad checks", test_name(test_id), failed);
        end
    endtask

    task automatic check_reset_state();
        logic [3:0][25:0] got;
        int               start;
        start = errors;
        got = {res_3, res_2, res_1, res_0};
        assert (out_valid === 1'b0) else begin
            $display("CHECK FAILED reset_state out_valid: expected 0, actual %b", out_valid);
            errors++;
        end
        for (int s = 0; s < 4; s++) begin
            assert (got[s] === '0) else begin
                $display("CHECK FAILED reset_state slot %0d: expected 0, actual %0d",
                         s, $signed(got[s]));
                errors++;
            end
        end
        report_test(3'd1, start);
    endtask

    task automatic run_table_test(input logic [2:0] test_id);
        int start;
        start = errors;
        active_test = test_id;
        for (int r = 0; r < table_rows; r++) begin
            if (vector_table[r].test_id == test_id) begin
                send_beat(vector_table[r].mat, vector_table[r].vec, vector_table[r].pat,
                          {vector_table[r].e3, vector_table[r].e2,
                           vector_table[r].e1, vector_table[r].e0}, test_id);
            end
        end
        in_valid = 1'b0;
        wait_drained(20);
        report_test(test_id, start);
    endtask

    task automatic run_random_test(input logic [2:0] test_id, input int beats,
                                   input logic with_gaps);
        int          start;
        int          sent;
        logic [31:0] mat;
        logic [31:0] vec;
        logic [2:0]  pat;
        start = errors;
        sent = 0;
        active_test = test_id;
        while (sent < beats) begin
            if (with_gaps && next_random_bits(1) == 0) begin
                idle_cycle();
            end else begin
                mat = next_random_bits(32);
                vec = next_random_bits(32);
                pat = 3'(next_random_bits(3));
                send_beat(mat, vec, pat, segment_sums(mat, vec, pat), test_id);
                sent++;
            end
        end
        in_valid = 1'b0;
        wait_drained(20);
        report_test(test_id, start);
    endtask

    initial begin
        rst = 1'b0;
        in_valid = 1'b0;
        mat_word = '0;
        vec_word = '0;
        pattern = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;
        check_reset_state();
        run_table_test(3'd2);
        run_table_test(3'd3);
        run_table_test(3'd4);
        run_random_test(3'd5, 16, 1'b0);
        run_random_test(3'd6, 24, 1'b1);
        $display("tests run %0d, passed %0d, failed %0d, bad checks %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
common/alu_fmt_pkg.sv
common/seg_pkg.sv
common/lane_if.sv
source/product_stage.sv
reduce/pair_merge_stage.sv
reduce/segment_pack_stage.sv
source/matvec_alu_top.sv
dv/tb_matvec_alu.sv
